//--- logic/periph_defs.svh
// Shared widths, address map and constants of the peripheral subsystem
// Included by the package and by every RTL file that needs a value from it

`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define PERIPH_ADDR_W   32
`define PERIPH_DATA_W   64
`define PERIPH_BE_W     8                       // One enable per data byte

// ----------------------------------------------------------------------
// Address map, base and length of each decoded window
// ----------------------------------------------------------------------
`define BOOT_BASE       32'h0001_0000
`define BOOT_LEN        32'h0001_0000
`define GPIO_BASE       32'h4000_0000
`define GPIO_LEN        32'h0000_1000

// Boot RAM depth in 64-bit words, aliased within its window
`define BOOT_RAM_WORDS  1024

// Read data returned for unmapped addresses and unused registers
`define ERR_RDATA       64'h0000_0000_DEAD_BEEF

// LEDs and DIP switches share one width
`define LED_W           8

`endif

//--- logic/periph_pkg.sv
// Types shared by the peripheral subsystem and its testbench
// Bus request and response structs plus the decode and register enums

`include "periph_defs.svh"

package periph_pkg;

    // ------------------------------------------------------------------
    // Strobe bus, one request per cycle with valid high
    // ------------------------------------------------------------------
    typedef struct packed {
        logic                      valid;   // Request strobe
        logic                      we;      // Write when set
        logic [`PERIPH_ADDR_W-1:0] addr;    // Byte address
        logic [`PERIPH_BE_W-1:0]   be;      // Byte enables
        logic [`PERIPH_DATA_W-1:0] wdata;
    } bus_req_t;

    // Response, always one cycle after its request
    typedef struct packed {
        logic                      valid;
        logic                      err;     // Unmapped address
        logic [`PERIPH_DATA_W-1:0] rdata;
    } bus_rsp_t;

    // ------------------------------------------------------------------
    // Decode result of the router
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        REGION_BOOT = 2'd0,
        REGION_GPIO = 2'd1,
        REGION_NONE = 2'd2
    } region_e;

    // GPIO register offsets, taken from address bits 5 to 3
    typedef enum logic [2:0] {
        GPIO_LED_DIP  = 3'd0,   // Write LEDs, read DIP switches
        GPIO_LED_READ = 3'd1    // Read back the LED register
    } gpio_reg_e;

endpackage

//--- logic/boot_ram.sv
// Boot RAM, single port with byte enables
// Every valid request registers the addressed word, so read data follows
// one cycle later and a write returns the word as it was before the write

`include "periph_defs.svh"

module boot_ram
(
    input  logic                      clk_i,
    input  periph_pkg::bus_req_t      req_i,
    output logic [`PERIPH_DATA_W-1:0] rdata_o
);

    // Word index sits right above the byte offset
    localparam int IDX_W  = $clog2(`BOOT_RAM_WORDS);
    localparam int IDX_LO = $clog2(`PERIPH_BE_W);

    logic [`PERIPH_DATA_W-1:0] mem [`BOOT_RAM_WORDS];
    logic [IDX_W-1:0]          idx;

    // Upper address bits ignored, the RAM aliases within its window
    assign idx = req_i.addr[IDX_LO +: IDX_W];

    // ------------------------------------------------------------------
    // Byte-enabled write
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (req_i.valid && req_i.we)
        begin
            for (int b = 0; b < `PERIPH_BE_W; b++)
            begin
                if (req_i.be[b])
                begin
                    mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Registered read, old data on a write
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (req_i.valid)
        begin
            rdata_o <= mem[idx];
        end
    end

endmodule

//--- logic/gpio_regs.sv
// GPIO register block
// Holds the LED register and returns the DIP switches or the LEDs
// through a registered read mux, one cycle after each request

`include "periph_defs.svh"

module gpio_regs
(
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  periph_pkg::bus_req_t      req_i,
    input  logic [`LED_W-1:0]         dip_switches_i,
    output logic [`LED_W-1:0]         leds_o,
    output logic [`PERIPH_DATA_W-1:0] rdata_o
);

    periph_pkg::gpio_reg_e     offset;
    logic [`PERIPH_DATA_W-1:0] rdata_d;

    // Register offset from address bits 5 to 3
    assign offset = periph_pkg::gpio_reg_e'(req_i.addr[5:3]);

    // ------------------------------------------------------------------
    // LED register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            leds_o <= '0;
        end
        else if (req_i.valid && req_i.we && req_i.be[0]
                 && offset == periph_pkg::GPIO_LED_DIP)
        begin
            leds_o <= req_i.wdata[`LED_W-1:0];   // Low byte only
        end
    end

    // ------------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------------
    always_comb
    begin
        case (offset)
            periph_pkg::GPIO_LED_DIP:  rdata_d = {{(`PERIPH_DATA_W-`LED_W){1'b0}}, dip_switches_i};
            periph_pkg::GPIO_LED_READ: rdata_d = {{(`PERIPH_DATA_W-`LED_W){1'b0}}, leds_o};
            default:                   rdata_d = `ERR_RDATA;   // Unused offset
        endcase
    end

    // Sampled with the request, held until the next one
    always_ff @(posedge clk_i)
    begin
        if (req_i.valid)
        begin
            rdata_o <= rdata_d;
        end
    end

endmodule

//--- logic/periph_router.sv
// Address router of the peripheral subsystem
// Matches each request against a base/mask table, steers it to one slave
// and builds the response one cycle later from that slave's read data.
// Addresses outside the table get err set and the filler read data.

`include "periph_defs.svh"

module periph_router
(
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  periph_pkg::bus_req_t      req_i,
    output periph_pkg::bus_rsp_t      rsp_o,

    // Boot RAM
    output periph_pkg::bus_req_t      boot_req_o,
    input  logic [`PERIPH_DATA_W-1:0] boot_rdata_i,

    // GPIO registers
    output periph_pkg::bus_req_t      gpio_req_o,
    input  logic [`PERIPH_DATA_W-1:0] gpio_rdata_i
);

    // ------------------------------------------------------------------
    // Address map table, one entry per slave
    // ------------------------------------------------------------------
    localparam int NUM_SLAVES = 2;

    localparam logic [NUM_SLAVES-1:0][`PERIPH_ADDR_W-1:0] BASE =
    {
        `GPIO_BASE,
        `BOOT_BASE
    };

    localparam logic [NUM_SLAVES-1:0][`PERIPH_ADDR_W-1:0] MASK =
    {
        `GPIO_LEN - 32'd1,
        `BOOT_LEN - 32'd1
    };

    logic [NUM_SLAVES-1:0] hit;             // Per-entry match
    periph_pkg::region_e   region;          // Decode of current request
    periph_pkg::region_e   region_q;        // Decode of previous request
    logic                  valid_q;

    // Base compare with the offset bits masked off
    always_comb
    begin
        for (int i = 0; i < NUM_SLAVES; i++)
        begin
            hit[i] = (req_i.addr & ~MASK[i]) == BASE[i];
        end
    end

    always_comb
    begin
        if (hit[0])
        begin
            region = periph_pkg::REGION_BOOT;
        end
        else if (hit[1])
        begin
            region = periph_pkg::REGION_GPIO;
        end
        else
        begin
            region = periph_pkg::REGION_NONE;   // UART, SPI, HID and holes
        end
    end

    // ------------------------------------------------------------------
    // Request steering, valid only toward the selected slave
    // ------------------------------------------------------------------
    always_comb
    begin
        boot_req_o       = req_i;
        gpio_req_o       = req_i;
        boot_req_o.valid = req_i.valid && (region == periph_pkg::REGION_BOOT);
        gpio_req_o.valid = req_i.valid && (region == periph_pkg::REGION_GPIO);
    end

    // Remember where the request went for the response cycle
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            valid_q  <= 1'b0;
            region_q <= periph_pkg::REGION_NONE;
        end
        else
        begin
            valid_q  <= req_i.valid;
            region_q <= region;
        end
    end

    // ------------------------------------------------------------------
    // Response mux
    // ------------------------------------------------------------------
    always_comb
    begin
        rsp_o.valid = valid_q;
        rsp_o.err   = 1'b0;
        case (region_q)
            periph_pkg::REGION_BOOT: rsp_o.rdata = boot_rdata_i;
            periph_pkg::REGION_GPIO: rsp_o.rdata = gpio_rdata_i;
            default:
            begin
                rsp_o.rdata = `ERR_RDATA;       // Error response
                rsp_o.err   = 1'b1;
            end
        endcase
    end

endmodule

//--- logic/periph_top.sv
// Peripheral subsystem top level
// Decodes the master's strobe bus onto the boot RAM and the GPIO block
// and returns one response per request, one cycle later

`include "periph_defs.svh"

module periph_top
(
    input  logic                   clk_i,
    input  logic                   reset_i,

    // Master side
    input  periph_pkg::bus_req_t   req_i,
    output periph_pkg::bus_rsp_t   rsp_o,

    // Board IO
    input  logic [`LED_W-1:0]      dip_switches_i,
    output logic [`LED_W-1:0]      leds_o
);

    // ------------------------------------------------------------------
    // Slave side wires
    // ------------------------------------------------------------------
    periph_pkg::bus_req_t      boot_req;
    periph_pkg::bus_req_t      gpio_req;
    logic [`PERIPH_DATA_W-1:0] boot_rdata;
    logic [`PERIPH_DATA_W-1:0] gpio_rdata;

    // Address decode and response mux
    periph_router i_router
    (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_i        (req_i),
        .rsp_o        (rsp_o),
        .boot_req_o   (boot_req),
        .boot_rdata_i (boot_rdata),
        .gpio_req_o   (gpio_req),
        .gpio_rdata_i (gpio_rdata)
    );

    // ------------------------------------------------------------------
    // Boot RAM
    // ------------------------------------------------------------------
    boot_ram i_boot_ram
    (
        .clk_i   (clk_i),
        .req_i   (boot_req),
        .rdata_o (boot_rdata)
    );

    // ------------------------------------------------------------------
    // GPIO registers
    // ------------------------------------------------------------------
    gpio_regs i_gpio_regs
    (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_i          (gpio_req),
        .dip_switches_i (dip_switches_i),
        .leds_o         (leds_o),
        .rdata_o        (gpio_rdata)
    );

endmodule

//--- verif/periph_tb_vectors.svh
// Directed stimulus for the peripheral subsystem testbench
// Columns: op, addr, be, wdata, dip, expected rdata, expected err, expected leds
// Expected rdata is only compared on reads

localparam int NUM_VECTORS = 26;

localparam vector_t VECTORS [NUM_VECTORS] =
'{
    // Boot RAM, full and partial writes
    '{OP_WR, 32'h0001_0008, 8'hFF, 64'h1122_3344_5566_7788, 8'h5A, 64'h0, 1'b0, 8'h00},
    '{OP_RD, 32'h0001_0008, 8'h00, 64'h0, 8'h5A, 64'h1122_3344_5566_7788, 1'b0, 8'h00},
    '{OP_WR, 32'h0001_0008, 8'h0F, 64'hAAAA_BBBB_CCCC_DDDD, 8'h5A, 64'h0, 1'b0, 8'h00},
    '{OP_RD, 32'h0001_0008, 8'h00, 64'h0, 8'h5A, 64'h1122_3344_CCCC_DDDD, 1'b0, 8'h00},
    '{OP_WR, 32'h0001_0008, 8'hA5, 64'hFFEE_DDCC_BBAA_9988, 8'h5A, 64'h0, 1'b0, 8'h00},
    '{OP_RD, 32'h0001_2008, 8'h00, 64'h0, 8'h5A, 64'hFF22_DD44_CCAA_DD88, 1'b0, 8'h00},
    '{OP_WR, 32'h0001_E010, 8'hFF, 64'h0123_4567_89AB_CDEF, 8'h5A, 64'h0, 1'b0, 8'h00},
    '{OP_RD, 32'h0001_0010, 8'h00, 64'h0, 8'h5A, 64'h0123_4567_89AB_CDEF, 1'b0, 8'h00},

    // GPIO, LED write and readback, DIP readout, unused offsets
    '{OP_WR, 32'h4000_0000, 8'h01, 64'h0000_0000_0000_00A5, 8'h5A, 64'h0, 1'b0, 8'hA5},
    '{OP_RD, 32'h4000_0008, 8'h00, 64'h0, 8'h5A, 64'h0000_0000_0000_00A5, 1'b0, 8'hA5},
    '{OP_WR, 32'h4000_0000, 8'hFE, 64'h0000_0000_0000_003C, 8'h5A, 64'h0, 1'b0, 8'hA5},
    '{OP_RD, 32'h4000_0008, 8'h00, 64'h0, 8'h5A, 64'h0000_0000_0000_00A5, 1'b0, 8'hA5},
    '{OP_RD, 32'h4000_0000, 8'h00, 64'h0, 8'h5A, 64'h0000_0000_0000_005A, 1'b0, 8'hA5},
    '{OP_RD, 32'h4000_0000, 8'h00, 64'h0, 8'hC3, 64'h0000_0000_0000_00C3, 1'b0, 8'hA5},
    '{OP_RD, 32'h4000_0010, 8'h00, 64'h0, 8'h5A, 64'h0000_0000_DEAD_BEEF, 1'b0, 8'hA5},
    '{OP_RD, 32'h4000_0038, 8'h00, 64'h0, 8'h5A, 64'h0000_0000_DEAD_BEEF, 1'b0, 8'hA5},

    // UART, SPI and HID windows, then holes around the mapped windows
    '{OP_RD, 32'h1000_0000, 8'h00, 64'h0, 8'h5A, 64'h0000_0000_DEAD_BEEF, 1'b1, 8'hA5},
    '{OP_WR, 32'h1000_0000, 8'hFF, 64'h0, 8'h5A, 64'h0, 1'b1, 8'hA5},
    '{OP_RD, 32'h2000_0000, 8'h00, 64'h0, 8'h5A, 64'h0000_0000_DEAD_BEEF, 1'b1, 8'hA5},
    '{OP_RD, 32'h5000_0000, 8'h00, 64'h0, 8'h5A, 64'h0000_0000_DEAD_BEEF, 1'b1, 8'hA5},
    '{OP_WR, 32'h4000_1000, 8'h01, 64'h0000_0000_0000_00FF, 8'h5A, 64'h0, 1'b1, 8'hA5},
    '{OP_WR, 32'h0002_0008, 8'hFF, 64'h0, 8'h5A, 64'h0, 1'b1, 8'hA5},
    '{OP_WR, 32'h0000_0008, 8'hFF, 64'h0, 8'h5A, 64'h0, 1'b1, 8'hA5},
    '{OP_RD, 32'h0000_0000, 8'h00, 64'h0, 8'h5A, 64'h0000_0000_DEAD_BEEF, 1'b1, 8'hA5},
    '{OP_RD, 32'h0001_0008, 8'h00, 64'h0, 8'h5A, 64'hFF22_DD44_CCAA_DD88, 1'b0, 8'hA5},
    '{OP_RD, 32'h4000_0008, 8'h00, 64'h0, 8'h5A, 64'h0000_0000_0000_00A5, 1'b0, 8'hA5}
};

//--- verif/periph_tb.sv
// Testbench of the peripheral subsystem
// Runs the directed vector table, then random boot RAM writes followed by
// back-to-back reads checked against a model array

`include "periph_defs.svh"

module periph_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic OP_RD       = 1'b0;
    localparam logic OP_WR       = 1'b1;
    localparam int   RSP_TIMEOUT = 20;  // Cycles
    localparam int   NUM_RANDOM  = 32;

    typedef struct packed {
        logic                      we;
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_BE_W-1:0]   be;
        logic [`PERIPH_DATA_W-1:0] wdata;
        logic [`LED_W-1:0]         dip;
        logic [`PERIPH_DATA_W-1:0] exp_rdata;
        logic                      exp_err;
        logic [`LED_W-1:0]         exp_leds;
    } vector_t;

    `include "periph_tb_vectors.svh"

    logic                      clk_i;
    logic                      reset_i;
    periph_pkg::bus_req_t      req_i;
    periph_pkg::bus_rsp_t      rsp_o;
    logic [`LED_W-1:0]         dip_switches_i;
    logic [`LED_W-1:0]         leds_o;

    periph_pkg::bus_rsp_t      rsp_seen;                   // Last captured response
    logic [31:0]               lfsr;
    logic [`PERIPH_DATA_W-1:0] model [`BOOT_RAM_WORDS];    // Expected RAM contents
    logic [9:0]                rd_idx [NUM_RANDOM];
    logic [`PERIPH_DATA_W-1:0] rnd;
    logic [9:0]                idx;
    logic [2:0]                alias_bits;
    vector_t                   vec;

    periph_top dut
    (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_i          (req_i),
        .rsp_o          (rsp_o),
        .dip_switches_i (dip_switches_i),
        .leds_o         (leds_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ 32'h8020_0003;    // x^32 + x^22 + x^2 + x + 1
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [`PERIPH_DATA_W-1:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr  = next_lfsr(lfsr);
            value = {value[`PERIPH_DATA_W-2:0], lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        $display("Testbench failed");
        $fatal(1, "Mismatch on %s", name);
    endtask

    // One request, then wait for its single response pulse
    task automatic issue_request(input logic we, input logic [31:0] addr,
                                 input logic [7:0] be, input logic [63:0] wdata,
                                 input logic [7:0] dip);
        periph_pkg::bus_req_t req;
        int                   cycles;
        logic                 got;
        req.valid = 1'b1;
        req.we    = we;
        req.addr  = addr;
        req.be    = be;
        req.wdata = wdata;
        @(posedge clk_i);
        req_i          <= req;
        dip_switches_i <= dip;
        @(posedge clk_i);
        req_i <= '0;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < RSP_TIMEOUT)
        begin
            @(negedge clk_i);
            if (rsp_o.valid)
            begin
                got      = 1'b1;
                rsp_seen = rsp_o;
            end
            cycles++;
        end
        if (!got)
        begin
            $display("No response arrived for the request to address %h", addr);
            $display("Testbench failed");
            $fatal(1, "Response timeout");
        end
        @(negedge clk_i);
        assert (rsp_o.valid === 1'b0)
            else report_mismatch("rsp_o.valid", 64'(rsp_o.valid), 64'd0);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial
    begin
        reset_i        = 1'b1;
        req_i          = '0;
        dip_switches_i = '0;
        lfsr           = 32'hdd9f;
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        assert (rsp_o.valid === 1'b0)
            else report_mismatch("rsp_o.valid", 64'(rsp_o.valid), 64'd0);
        assert (leds_o === '0)
            else report_mismatch("leds_o", 64'(leds_o), 64'd0);

        for (int v = 0; v < NUM_VECTORS; v++)
        begin
            vec = VECTORS[v];
            issue_request(vec.we, vec.addr, vec.be, vec.wdata, vec.dip);
            assert (rsp_seen.err === vec.exp_err)
                else report_mismatch("rsp_o.err", 64'(rsp_seen.err), 64'(vec.exp_err));
            if (vec.we == OP_RD)
            begin
                assert (rsp_seen.rdata === vec.exp_rdata)
                    else report_mismatch("rsp_o.rdata", rsp_seen.rdata, vec.exp_rdata);
            end
            assert (leds_o === vec.exp_leds)
                else report_mismatch("leds_o", 64'(leds_o), 64'(vec.exp_leds));
        end

        // Random full-word writes anywhere in the aliased window
        for (int w = 0; w < NUM_RANDOM; w++)
        begin
            take_bits(10, rnd);
            idx = rnd[9:0];
            take_bits(3, rnd);
            alias_bits = rnd[2:0];
            take_bits(64, rnd);
            issue_request(OP_WR, {16'h0001, alias_bits, idx, 3'b000}, 8'hFF, rnd, 8'h5A);
            assert (rsp_seen.err === 1'b0)
                else report_mismatch("rsp_o.err", 64'(rsp_seen.err), 64'd0);
            model[idx] = rnd;
            rd_idx[w]  = idx;
        end

        // Back-to-back reads, each response one cycle after its request
        for (int k = 0; k <= NUM_RANDOM; k++)
        begin
            take_bits(3, rnd);
            @(posedge clk_i);
            if (k < NUM_RANDOM)
            begin
                req_i <= '{1'b1, OP_RD, {16'h0001, rnd[2:0], rd_idx[k], 3'b000}, 8'h00, 64'h0};
            end
            else
            begin
                req_i <= '0;
            end
            @(negedge clk_i);
            if (k > 0)
            begin
                assert (rsp_o.valid === 1'b1)
                    else report_mismatch("rsp_o.valid", 64'(rsp_o.valid), 64'd1);
                assert (rsp_o.err === 1'b0)
                    else report_mismatch("rsp_o.err", 64'(rsp_o.err), 64'd0);
                assert (rsp_o.rdata === model[rd_idx[k-1]])
                    else report_mismatch("rsp_o.rdata", rsp_o.rdata, model[rd_idx[k-1]]);
            end
        end

        @(posedge clk_i);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- list.f
+incdir+logic
+incdir+verif
logic/periph_pkg.sv
logic/boot_ram.sv
logic/gpio_regs.sv
logic/periph_router.sv
logic/periph_top.sv
verif/periph_tb.sv

//--- Makefile
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= periph_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
